//--- hdl/neuron_pkg.sv
////////////////////
// Neuron shared definitions
// Q8.24 types, handshake structs, opcodes and tanh segment constants
////////////////////
package neuron_pkg;

	// Q8.24 signed word and wide accumulator
	typedef logic signed [31:0] fixed_t;
	typedef logic signed [47:0] acc_t;

	localparam int FRAC_BITS = 24;

	localparam fixed_t FIX_ONE = 32'sh0100_0000;
	localparam fixed_t FIX_MAX = 32'sh7FFF_FFFF;
	localparam fixed_t FIX_MIN = 32'sh8000_0000;

	////////////////////
	// Tanh segment table
	////////////////////

	// Upper bounds of each segment, inclusive
	localparam fixed_t TANH_BP0 = 32'sh0033_3333;
	localparam fixed_t TANH_BP1 = FIX_ONE;
	localparam fixed_t TANH_BP2 = 32'sh01B8_51EC;
	localparam fixed_t TANH_BP3 = 32'sh0200_0000;

	// Offsets added to the scaled magnitude
	localparam fixed_t TANH_K1 = 32'sh000C_CCCD;
	localparam fixed_t TANH_K2 = 32'sh0080_0000;
	localparam fixed_t TANH_K3 = 32'sh00B8_51EC;

	////////////////////
	// Opcodes and states
	////////////////////

	typedef enum logic [1:0] {
		ACT_LINEAR = 2'd0,
		ACT_RELU   = 2'd1,
		ACT_TANH   = 2'd2
	} act_op_e;

	typedef enum logic [2:0] {
		ST_IDLE = 3'd0,
		ST_LOAD = 3'd1,
		ST_ACC  = 3'd2,
		ST_ACT  = 3'd3,
		ST_ACK  = 3'd4
	} ctrl_state_e;

	// Request side fields other than the operand vectors
	typedef struct packed {
		act_op_e op;
		fixed_t  bias;
	} neuron_req_t;

	// Result and pre-activation overflow flag
	typedef struct packed {
		fixed_t value;
		logic   sat;
	} neuron_rsp_t;

	typedef struct packed {
		logic load;
		logic acc_en;
	} mac_cmd_t;

endpackage

//--- hdl/tanh_pwl.sv
////////////////////
// Piecewise-linear tanh
// Four shift-and-add segments on the magnitude, sign restored after
////////////////////
`timescale 1ns/1ps

module tanh_pwl (
	input  neuron_pkg::fixed_t i_x,
	output neuron_pkg::fixed_t o_y
);

	logic               neg;
	neuron_pkg::fixed_t a;
	neuron_pkg::fixed_t a_half;
	neuron_pkg::fixed_t a_qtr;
	neuron_pkg::fixed_t a_eighth;
	neuron_pkg::fixed_t y_mag;

	assign neg = i_x[31];

	////////////////////
	// Magnitude
	////////////////////
	always_comb
	begin
		// Most negative input has no positive twin
		if (i_x == neuron_pkg::FIX_MIN)
			a = neuron_pkg::FIX_MAX;
		else if (neg)
			a = -i_x;
		else
			a = i_x;
	end

	// Magnitude is never negative so plain shifts are safe
	assign a_half   = a >> 1;
	assign a_qtr    = a >> 2;
	assign a_eighth = a >> 3;

	////////////////////
	// Segment select
	////////////////////
	always_comb
	begin
		if (a <= neuron_pkg::TANH_BP0)
		begin
			// Near zero tanh follows the input
			y_mag = a;
		end
		else if (a <= neuron_pkg::TANH_BP1)
		begin
			y_mag = a_half + a_qtr + neuron_pkg::TANH_K1;
		end
		else if (a <= neuron_pkg::TANH_BP2)
		begin
			y_mag = a_qtr + neuron_pkg::TANH_K2;
		end
		else if (a <= neuron_pkg::TANH_BP3)
		begin
			y_mag = a_eighth + neuron_pkg::TANH_K3;
		end
		else
		begin
			// Saturated region
			y_mag = neuron_pkg::FIX_ONE;
		end
	end

	assign o_y = neg ? -y_mag : y_mag;

	// Output stays within the unit range
	always_comb
	begin
		assert ((o_y <= neuron_pkg::FIX_ONE) && (o_y >= -neuron_pkg::FIX_ONE))
			else $error("tanh output %h outside unit range", o_y);
	end

endmodule

//--- hdl/neuron_mac.sv
////////////////////
// Neuron MAC
// Operand capture, one Q8.24 product per cycle, saturated sum
////////////////////
`timescale 1ns/1ps

module neuron_mac #(
	parameter int N_INPUTS = 4,
	localparam int IDX_W = (N_INPUTS > 1) ? $clog2(N_INPUTS) : 1,
	localparam int FW    = $bits(neuron_pkg::fixed_t),
	localparam int VEC_W = N_INPUTS * FW
) (
	input  logic                  i_clk,
	input  logic                  i_arst_n,
	input  neuron_pkg::mac_cmd_t  i_cmd,
	input  logic [IDX_W-1:0]      i_idx,
	input  neuron_pkg::fixed_t    i_bias,
	input  logic [VEC_W-1:0]      i_x,
	input  logic [VEC_W-1:0]      i_w,
	output neuron_pkg::fixed_t    o_sum,
	output logic                  o_ovf
);

	// Clamp limits widened to accumulator size
	localparam neuron_pkg::acc_t SAT_HI = neuron_pkg::acc_t'(neuron_pkg::FIX_MAX);
	localparam neuron_pkg::acc_t SAT_LO = neuron_pkg::acc_t'(neuron_pkg::FIX_MIN);

	neuron_pkg::fixed_t x_q [N_INPUTS];
	neuron_pkg::fixed_t w_q [N_INPUTS];
	neuron_pkg::fixed_t x_sel;
	neuron_pkg::fixed_t w_sel;
	logic signed [63:0] prod;
	neuron_pkg::acc_t   prod_sh;
	neuron_pkg::acc_t   acc_q;

	// Operand capture on load
	always_ff @(posedge i_clk)
	begin
		if (i_cmd.load)
		begin
			for (int k = 0; k < N_INPUTS; k++)
			begin
				x_q[k] <= i_x[k*FW +: FW];
				w_q[k] <= i_w[k*FW +: FW];
			end
		end
	end

	////////////////////
	// Multiply
	////////////////////
	assign x_sel = x_q[i_idx];
	assign w_sel = w_q[i_idx];

	// Full Q16.48 product, truncated back to 24 fraction bits
	assign prod    = x_sel * w_sel;
	assign prod_sh = neuron_pkg::acc_t'(prod >>> neuron_pkg::FRAC_BITS);

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			acc_q <= '0;
		else if (i_cmd.load)
			acc_q <= neuron_pkg::acc_t'(i_bias);
		else if (i_cmd.acc_en)
			acc_q <= acc_q + prod_sh;
	end

	////////////////////
	// Saturation
	////////////////////
	always_comb
	begin
		o_ovf = 1'b1;
		if (acc_q > SAT_HI)
			o_sum = neuron_pkg::FIX_MAX;
		else if (acc_q < SAT_LO)
			o_sum = neuron_pkg::FIX_MIN;
		else
		begin
			o_sum = acc_q[FW-1:0];
			o_ovf = 1'b0;
		end
	end

	a_idx_range: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_cmd.acc_en |-> (int'(i_idx) < N_INPUTS))
		else $error("MAC index %0d out of range", i_idx);

endmodule

//--- hdl/neuron_ctrl.sv
////////////////////
// Neuron controller
// Four-phase handshake, MAC sequencing and activation result register
////////////////////
`timescale 1ns/1ps

module neuron_ctrl #(
	parameter int N_INPUTS = 4,
	localparam int IDX_W = (N_INPUTS > 1) ? $clog2(N_INPUTS) : 1
) (
	input  logic                     i_clk,
	input  logic                     i_arst_n,
	input  logic                     i_req,
	input  neuron_pkg::neuron_req_t  i_req_data,
	input  neuron_pkg::fixed_t       i_sum,
	input  logic                     i_ovf,
	input  neuron_pkg::fixed_t       i_tanh,
	output logic                     o_ack,
	output neuron_pkg::neuron_rsp_t  o_rsp,
	output neuron_pkg::mac_cmd_t     o_mac_cmd,
	output logic [IDX_W-1:0]         o_idx
);

	neuron_pkg::ctrl_state_e state_q;
	neuron_pkg::ctrl_state_e state_d;
	neuron_pkg::act_op_e     op_q;
	neuron_pkg::fixed_t      act_y;
	logic [IDX_W-1:0]        idx_q;
	logic                    last_idx;

	assign last_idx = (idx_q == IDX_W'(N_INPUTS - 1));

	////////////////////
	// Next state
	////////////////////
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			neuron_pkg::ST_IDLE:
				// Previous handshake must be fully closed
				if (i_req && !o_ack)
					state_d = neuron_pkg::ST_LOAD;
			neuron_pkg::ST_LOAD:
				state_d = neuron_pkg::ST_ACC;
			neuron_pkg::ST_ACC:
				if (last_idx)
					state_d = neuron_pkg::ST_ACT;
			neuron_pkg::ST_ACT:
				state_d = neuron_pkg::ST_ACK;
			neuron_pkg::ST_ACK:
				// Stay here while the requester holds i_req
				if (!i_req && o_ack)
					state_d = neuron_pkg::ST_IDLE;
			default:
				state_d = neuron_pkg::ST_IDLE;
		endcase
	end

	// Activation chosen by the latched opcode
	always_comb
	begin
		case (op_q)
			neuron_pkg::ACT_RELU:
				act_y = (i_sum < 0) ? '0 : i_sum;
			neuron_pkg::ACT_TANH:
				act_y = i_tanh;
			default:
				act_y = i_sum;
		endcase
	end

	////////////////////
	// Registers
	////////////////////
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			state_q <= neuron_pkg::ST_IDLE;
			op_q    <= neuron_pkg::ACT_LINEAR;
			idx_q   <= '0;
			o_ack   <= 1'b0;
			o_rsp   <= '0;
		end
		else
		begin
			state_q <= state_d;
			// One cycle behind the state so ack rises and falls a cycle late
			o_ack   <= (state_q == neuron_pkg::ST_ACK);

			if (state_q == neuron_pkg::ST_IDLE && state_d == neuron_pkg::ST_LOAD)
				op_q <= i_req_data.op;

			if (state_q == neuron_pkg::ST_ACC)
				idx_q <= last_idx ? '0 : idx_q + 1'b1;

			// Result held until the next request reaches ST_ACT
			if (state_q == neuron_pkg::ST_ACT)
			begin
				o_rsp.value <= act_y;
				o_rsp.sat   <= i_ovf;
			end
		end
	end

	assign o_mac_cmd.load   = (state_q == neuron_pkg::ST_LOAD);
	assign o_mac_cmd.acc_en = (state_q == neuron_pkg::ST_ACC);
	assign o_idx            = idx_q;

	////////////////////
	// Protocol checks
	////////////////////
	a_ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		$rose(o_ack) |-> $past(i_req))
		else $error("o_ack rose without a pending request");

	a_req_after_ack: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		$rose(i_req) |-> !o_ack)
		else $error("i_req rose while o_ack still high");

	// Accumulate run always opens right after the operand load
	a_acc_after_load: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		$rose(o_mac_cmd.acc_en) |-> $past(o_mac_cmd.load))
		else $error("MAC accumulate started without an operand load");

endmodule

//--- hdl/neuron_top.sv
////////////////////
// Neuron top level
// Controller, MAC and tanh joined behind a req/ack handshake
////////////////////
`timescale 1ns/1ps

module neuron_top #(
	parameter int N_INPUTS = 4,
	localparam int IDX_W = (N_INPUTS > 1) ? $clog2(N_INPUTS) : 1,
	localparam int VEC_W = N_INPUTS * $bits(neuron_pkg::fixed_t)
) (
	input  logic                     i_clk,
	input  logic                     i_arst_n,
	input  logic                     i_req,
	input  neuron_pkg::neuron_req_t  i_req_data,
	input  logic [VEC_W-1:0]         i_x,
	input  logic [VEC_W-1:0]         i_w,
	output logic                     o_ack,
	output neuron_pkg::neuron_rsp_t  o_rsp
);

	neuron_pkg::mac_cmd_t mac_cmd;
	logic [IDX_W-1:0]     mac_idx;
	neuron_pkg::fixed_t   mac_sum;
	logic                 mac_ovf;
	neuron_pkg::fixed_t   tanh_y;

	neuron_ctrl #(.N_INPUTS(N_INPUTS)) u_ctrl (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_req      (i_req),
		.i_req_data (i_req_data),
		.i_sum      (mac_sum),
		.i_ovf      (mac_ovf),
		.i_tanh     (tanh_y),
		.o_ack      (o_ack),
		.o_rsp      (o_rsp),
		.o_mac_cmd  (mac_cmd),
		.o_idx      (mac_idx)
	);

	neuron_mac #(.N_INPUTS(N_INPUTS)) u_mac (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_cmd    (mac_cmd),
		.i_idx    (mac_idx),
		.i_bias   (i_req_data.bias),
		.i_x      (i_x),
		.i_w      (i_w),
		.o_sum    (mac_sum),
		.o_ovf    (mac_ovf)
	);

	// Tanh works on the saturated sum
	tanh_pwl u_tanh (
		.i_x (mac_sum),
		.o_y (tanh_y)
	);

endmodule

//--- include/neuron_tb_checks.svh
////////////////////
// Neuron testbench checks
// Compare tasks for result values and flags, with running counters
////////////////////
`ifndef NEURON_TB_CHECKS_SVH
`define NEURON_TB_CHECKS_SVH

int n_checks = 0;
int n_errors = 0;

// Result word of the neuron
task automatic check_value(
	input string              name,
	input neuron_pkg::fixed_t exp_v,
	input neuron_pkg::fixed_t act_v
);
	n_checks++;
	if (act_v !== exp_v)
	begin
		n_errors++;
		$display("mismatch %s value: expected %h, actual %h", name, exp_v, act_v);
	end
endtask

// Single-bit status such as sat or ack
task automatic check_flag(
	input string name,
	input logic  exp_f,
	input logic  act_f
);
	n_checks++;
	if (act_f !== exp_f)
	begin
		n_errors++;
		$display("mismatch %s flag: expected %b, actual %b", name, exp_f, act_f);
	end
endtask

`endif

//--- verif/neuron_tb.sv
////////////////////
// Neuron testbench
// Table-driven four-phase requests checked against an integer model
////////////////////
`timescale 1ns/1ps

module neuron_tb;

	localparam int N_INPUTS    = 4;
	localparam int VEC_W       = N_INPUTS * 32;
	localparam int N_DIRECTED  = 16;
	localparam int N_TESTS     = N_DIRECTED + 12;
	localparam int HOLD_TEST   = 5;
	localparam int WAIT_LIMIT  = N_INPUTS + 3 + 8;
	localparam int CYCLE_LIMIT = N_TESTS * (N_INPUTS + 3 + 8) + 5 + 100;

	// Tanh segment table as given for the neuron
	localparam longint REF_BP0 = 64'h0033_3333;
	localparam longint REF_BP1 = 64'h0100_0000;
	localparam longint REF_BP2 = 64'h01B8_51EC;
	localparam longint REF_BP3 = 64'h0200_0000;
	localparam longint REF_K1  = 64'h000C_CCCD;
	localparam longint REF_K2  = 64'h0080_0000;
	localparam longint REF_K3  = 64'h00B8_51EC;
	localparam longint REF_ONE = 64'h0100_0000;

	typedef logic [VEC_W-1:0] vec_t;

	typedef struct packed {
		neuron_pkg::act_op_e op;
		neuron_pkg::fixed_t  bias;
		vec_t                x;
		vec_t                w;
	} stim_t;

	logic                    i_clk = 1'b0;
	logic                    i_arst_n;
	logic                    i_req;
	neuron_pkg::neuron_req_t i_req_data;
	vec_t                    i_x;
	vec_t                    i_w;
	logic                    o_ack;
	neuron_pkg::neuron_rsp_t o_rsp;

	stim_t stim [N_TESTS];
	string tname [N_TESTS];
	logic  hung = 1'b0;
	int    cycles = 0;

	`include "neuron_tb_checks.svh"

	neuron_top #(.N_INPUTS(N_INPUTS)) neuron_top_i (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_req      (i_req),
		.i_req_data (i_req_data),
		.i_x        (i_x),
		.i_w        (i_w),
		.o_ack      (o_ack),
		.o_rsp      (o_rsp)
	);

	always #20 i_clk = ~i_clk;

	////////////////////
	// Stimulus helpers
	////////////////////
	function automatic neuron_pkg::fixed_t to_fix(input real r);
		return neuron_pkg::fixed_t'($rtoi(r * 16777216.0));
	endfunction

	function automatic vec_t make_vec(input neuron_pkg::fixed_t a, b, c, d);
		return {d, c, b, a};
	endfunction

	// Uniform value in the range -span to +span
	function automatic neuron_pkg::fixed_t rand_fix(input neuron_pkg::fixed_t span);
		longint r;
		r = longint'($urandom) % (2 * longint'(span) + 1);
		return neuron_pkg::fixed_t'(r - longint'(span));
	endfunction

	task automatic set_entry(input int i, input string name, input neuron_pkg::act_op_e op,
		input neuron_pkg::fixed_t bias, input vec_t x, input vec_t w);
		tname[i] = name;
		stim[i]  = '{op: op, bias: bias, x: x, w: w};
	endtask

	task automatic fill_table();
		neuron_pkg::fixed_t big;
		big = to_fix(100.0);
		set_entry(0, "lin_mixed", neuron_pkg::ACT_LINEAR, to_fix(0.1),
			make_vec(to_fix(1.5), to_fix(-2.25), to_fix(0.75), to_fix(-0.125)),
			make_vec(to_fix(0.5), to_fix(1.25), to_fix(-3.0), to_fix(-2.0)));
		set_entry(1, "lin_trunc", neuron_pkg::ACT_LINEAR, to_fix(-1.0),
			make_vec(to_fix(-0.3), to_fix(0.7), to_fix(1.0 / 3.0), to_fix(-5.5)),
			make_vec(to_fix(0.9), to_fix(-0.6), to_fix(3.3), to_fix(0.01)));
		set_entry(2, "sat_pos", neuron_pkg::ACT_LINEAR, '0,
			make_vec(big, big, big, big), make_vec(big, big, big, big));
		set_entry(3, "sat_neg", neuron_pkg::ACT_LINEAR, '0,
			make_vec(big, big, big, big), make_vec(-big, -big, -big, -big));
		set_entry(4, "relu_neg", neuron_pkg::ACT_RELU, to_fix(0.5),
			make_vec(to_fix(1.0), to_fix(2.0), '0, '0),
			make_vec(to_fix(-1.0), to_fix(-1.0), '0, '0));
		set_entry(5, "relu_pos", neuron_pkg::ACT_RELU, to_fix(2.75), '0, '0);
		// Tanh points ride on the bias with zero operands
		set_entry(6, "tanh_bp0", neuron_pkg::ACT_TANH, 32'sh0033_3333, '0, '0);
		set_entry(7, "tanh_bp1_neg", neuron_pkg::ACT_TANH, to_fix(-1.0), '0, '0);
		set_entry(8, "tanh_bp2", neuron_pkg::ACT_TANH, 32'sh01B8_51EC, '0, '0);
		set_entry(9, "tanh_bp3_neg", neuron_pkg::ACT_TANH, to_fix(-2.0), '0, '0);
		set_entry(10, "tanh_seg0_neg", neuron_pkg::ACT_TANH, to_fix(-0.1), '0, '0);
		set_entry(11, "tanh_seg1_neg", neuron_pkg::ACT_TANH, to_fix(-0.6), '0, '0);
		set_entry(12, "tanh_seg2", neuron_pkg::ACT_TANH, to_fix(1.3), '0, '0);
		set_entry(13, "tanh_seg3_neg", neuron_pkg::ACT_TANH, to_fix(-1.9), '0, '0);
		set_entry(14, "tanh_beyond", neuron_pkg::ACT_TANH, to_fix(2.5), '0, '0);
		set_entry(15, "tanh_sat_neg", neuron_pkg::ACT_TANH, '0,
			make_vec(big, big, big, big), make_vec(-big, -big, -big, -big));
		for (int i = N_DIRECTED; i < N_TESTS; i++)
		begin
			set_entry(i, $sformatf("rand_%0d", i - N_DIRECTED),
				neuron_pkg::act_op_e'(i % 3), rand_fix(to_fix(3.0)),
				make_vec(rand_fix(to_fix(3.0)), rand_fix(to_fix(3.0)),
					rand_fix(to_fix(3.0)), rand_fix(to_fix(3.0))),
				make_vec(rand_fix(to_fix(0.25)), rand_fix(to_fix(0.25)),
					rand_fix(to_fix(0.25)), rand_fix(to_fix(0.25))));
		end
	endtask

	////////////////////
	// Reference model
	////////////////////
	function automatic neuron_pkg::fixed_t tanh_ref(input neuron_pkg::fixed_t v);
		longint a;
		longint y;
		a = longint'($signed(v));
		if (a < 0)
			a = -a;
		if (a > 64'sd2147483647)
			a = 64'sd2147483647;
		if (a <= REF_BP0)
			y = a;
		else if (a <= REF_BP1)
			y = (a >> 1) + (a >> 2) + REF_K1;
		else if (a <= REF_BP2)
			y = (a >> 2) + REF_K2;
		else if (a <= REF_BP3)
			y = (a >> 3) + REF_K3;
		else
			y = REF_ONE;
		return neuron_pkg::fixed_t'(($signed(v) < 0) ? -y : y);
	endfunction

	function automatic neuron_pkg::neuron_rsp_t expect_rsp(input stim_t s);
		longint                  acc;
		longint                  xk;
		longint                  wk;
		neuron_pkg::fixed_t      sum;
		neuron_pkg::neuron_rsp_t r;
		acc   = longint'($signed(s.bias));
		r.sat = 1'b0;
		for (int k = 0; k < N_INPUTS; k++)
		begin
			xk  = longint'($signed(s.x[k*32 +: 32]));
			wk  = longint'($signed(s.w[k*32 +: 32]));
			acc = acc + ((xk * wk) >>> 24);
		end
		if (acc > 64'sd2147483647)
			sum = 32'sh7FFF_FFFF;
		else if (acc < -64'sd2147483648)
			sum = 32'sh8000_0000;
		else
			sum = neuron_pkg::fixed_t'(acc);
		r.sat = (acc > 64'sd2147483647) || (acc < -64'sd2147483648);
		case (s.op)
			neuron_pkg::ACT_RELU:
				r.value = (sum < 0) ? '0 : sum;
			neuron_pkg::ACT_TANH:
				r.value = tanh_ref(sum);
			default:
				r.value = sum;
		endcase
		return r;
	endfunction

	////////////////////
	// Handshake driver
	////////////////////
	task automatic wait_ack(input logic level, output logic ok);
		int n;
		n  = 0;
		ok = 1'b1;
		while (o_ack !== level && ok)
		begin
			@(posedge i_clk);
			#2;
			n++;
			if (n > WAIT_LIMIT)
				ok = 1'b0;
		end
	endtask

	task automatic run_test(input int i);
		neuron_pkg::neuron_rsp_t exp_rsp;
		logic                    ok;
		int                      err0;
		err0    = n_errors;
		exp_rsp = expect_rsp(stim[i]);
		i_req_data.op   = stim[i].op;
		i_req_data.bias = stim[i].bias;
		i_x   = stim[i].x;
		i_w   = stim[i].w;
		i_req = 1'b1;
		wait_ack(1'b1, ok);
		if (!ok)
		begin
			$display("test %s: DUT stopped responding, o_ack never rose", tname[i]);
			hung = 1'b1;
			return;
		end
		check_value(tname[i], exp_rsp.value, o_rsp.value);
		check_flag(tname[i], exp_rsp.sat, o_rsp.sat);
		// Slow requester keeps i_req high for a while
		if (i == HOLD_TEST)
		begin
			repeat (5)
			begin
				@(posedge i_clk);
				#2;
				check_flag({tname[i], "_ack_hold"}, 1'b1, o_ack);
			end
		end
		@(posedge i_clk);
		#2;
		i_req = 1'b0;
		wait_ack(1'b0, ok);
		if (!ok)
		begin
			$display("test %s: DUT stopped responding, o_ack never fell", tname[i]);
			hung = 1'b1;
			return;
		end
		$display("test %-14s %s", tname[i], (n_errors == err0) ? "ok" : "FAILED");
	endtask

	////////////////////
	// Main sequence
	////////////////////
	initial
	begin
		i_arst_n   = 1'b0;
		i_req      = 1'b0;
		i_req_data = '0;
		i_x        = '0;
		i_w        = '0;
		void'($urandom(32'h7199_6753));
		fill_table();
		repeat (5) @(posedge i_clk);
		#2;
		i_arst_n = 1'b1;
		check_flag("reset_ack", 1'b0, o_ack);
		check_value("reset_rsp", '0, o_rsp.value);
		check_flag("reset_sat", 1'b0, o_rsp.sat);
		for (int i = 0; i < N_TESTS; i++)
		begin
			if (!hung)
				run_test(i);
		end
		$display("tests %0d, checks %0d, errors %0d", N_TESTS, n_checks, n_errors);
		if (n_errors == 0 && !hung)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Run-length watchdog
	initial
	begin
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge i_clk);
			cycles++;
		end
		$display("DUT stopped responding: run exceeded %0d cycles", CYCLE_LIMIT);
		$display("Regression failed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+include
hdl/neuron_pkg.sv
hdl/tanh_pwl.sv
hdl/neuron_mac.sv
hdl/neuron_ctrl.sv
hdl/neuron_top.sv
verif/neuron_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the neuron testbench with Verilator and run it.
# Exit status is zero only when the pass line shows up in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module neuron_tb -o neuron_sim \
	&& ./obj_dir/neuron_sim | tee /dev/stderr | grep -qx "Regression passed" \
	&& echo "run_sim: PASS" \
	|| { echo "run_sim: FAIL"; exit 1; }

exit 0
